// ==== sim.f ====
+incdir+test
logic/osf_pkg.sv
logic/fp_param_decoder.sv
logic/oversample_filter.sv
logic/osf_result_stage.sv
logic/osf_channel_top.sv
test/osf_tb.sv

// ==== test/osf_checks.svh ====
`ifndef OSF_CHECKS_SVH
`define OSF_CHECKS_SVH

//////////////////////////////
// expected blocks
//////////////////////////////

typedef struct packed {
	logic [31:0]             acc;	// edge that took the last sample
	logic                    sat;
	logic signed [W_OUT-1:0] val;
} expect_t;

localparam longint OUT_HI = (longint'(1) << (W_OUT - 1)) - 1;
localparam longint OUT_LO = -OUT_HI - 1;

expect_t exp_q[$];
int      err_value = 0;
int      err_timing = 0;
int      err_other = 0;
int      blocks_seen = 0;

// channel model, decoder side then filter side
osf_params_t m_stage;
logic        m_armed;
logic        m_active;
logic        m_update;
logic [3:0]  m_os;		// live log2 ratio
logic [15:0] m_delay;	// live settling delay
osf_state_e  m_st;
int          m_cnt;
longint      m_sum;

// floor of s / 2^os, division alone truncates toward zero
function automatic longint floor_avg(longint s, int os);
	longint r;
	longint q;
	r = longint'(1) << os;
	q = s / r;
	if (s < 0 && s % r != 0)
		q = q - 1;
	return q;
endfunction

// one clock edge of the channel, register values from before the edge
task automatic model_step();
	expect_t e;
	longint  q;
	int      n;
	logic    block_end;	// last sample of a block taken on this edge
	if (reset_in) begin
		m_stage  = '0;
		m_armed  = 1'b0;
		m_active = 1'b0;
		m_update = 1'b0;
		m_os     = '0;
		m_delay  = '0;
		m_st     = ST_IDLE;
		m_cnt    = 0;
		m_sum    = 0;
	end else begin
		block_end = 1'b0;
		if (!m_active) begin	// parked, partial block gone
			m_st  = ST_IDLE;
			m_cnt = 0;
			m_sum = 0;
		end else begin
			case (m_st)
				ST_IDLE: begin
					m_st  = ST_SAMPLE;	// no settling on restart
					m_cnt = 0;
					m_sum = 0;
				end
				ST_SAMPLE: begin
					if (data_valid_in) begin
						m_sum = m_sum + data_in;
						m_cnt = m_cnt + 1;
						if (m_cnt >= (1 << m_os)) begin
							m_st      = ST_SEND;
							block_end = 1'b1;
						end
					end
				end
				ST_SEND: begin
					m_st  = ST_DELAY;	// send-cycle sample never counted
					m_cnt = 0;
					m_sum = 0;
				end
				default: begin
					n = m_cnt + (data_valid_in ? 1 : 0);	// discarded samples
					if (n >= m_delay) begin
						m_st  = ST_SAMPLE;
						m_cnt = 0;
					end else
						m_cnt = n;
				end
			endcase
		end
		if (m_update) begin
			m_os    = m_stage.os;
			m_delay = m_stage.cycle_delay;
		end
		// divided by the ratio that is live during the send cycle
		if (block_end) begin
			q     = floor_avg(m_sum, m_os);
			e.acc = cyc;
			e.sat = (q > OUT_HI) || (q < OUT_LO);
			if (q > OUT_HI)
				q = OUT_HI;
			else if (q < OUT_LO)
				q = OUT_LO;
			e.val = W_OUT'(q);
			exp_q.push_back(e);
		end
		m_update = 1'b0;
		if (cmd_valid) begin
			case (cmd.op)
				OP_SET_OS:     m_stage.os = (cmd.data[3:0] > MAX_OS) ? 4'(MAX_OS) : cmd.data[3:0];
				OP_SET_DELAY:  m_stage.cycle_delay = cmd.data;
				OP_ACTIVATE:   m_active = 1'b1;
				OP_DEACTIVATE: m_active = 1'b0;
				OP_ARM:        m_armed = 1'b1;
				OP_DISARM:     m_armed = 1'b0;
				OP_UPDATE:     m_update = m_armed;
				default:       ;	// nop
			endcase
		end
	end
endtask

//////////////////////////////
// compares
//////////////////////////////

task automatic check_sample(string name, logic signed [W_OUT-1:0] exp_val, logic exp_sat,
		logic signed [W_OUT-1:0] act_val, logic act_sat);
	if (act_val !== exp_val || act_sat !== exp_sat) begin
		err_value++;
		$display("Fail %s: expected %0d sat %0b, actual %0d sat %0b",
			name, exp_val, exp_sat, act_val, act_sat);
	end
endtask

task automatic check_strobe(string name, logic [31:0] exp_cyc, logic [31:0] act_cyc);
	if (act_cyc !== exp_cyc) begin
		err_timing++;
		$display("Fail %s valid cycle: expected %0d, actual %0d", name, exp_cyc, act_cyc);
	end
endtask

// called mid-cycle, outputs settled since the last edge
task automatic watch_outputs();
	expect_t e;
	// blocks stay pending two cycles past their slot, a late pulse is a timing error
	while (exp_q.size() != 0 && exp_q[0].acc + 3 < cyc) begin
		e = exp_q.pop_front();
		err_other++;
		$display("ERROR %s: block ending at cycle %0d never produced an output", cur_test, e.acc);
	end
	if (data_valid_out === 1'b1) begin
		if (exp_q.size() == 0) begin
			err_other++;
			$display("ERROR %s: output pulse at cycle %0d with no block expected", cur_test, cyc);
		end else begin
			e = exp_q.pop_front();
			blocks_seen++;
			check_strobe(cur_test, e.acc + 1, cyc);	// second cycle after the last sample
			check_sample(cur_test, e.val, e.sat, data_out, sat_out);
		end
	end else if (sat_out !== 1'b0) begin
		err_other++;
		$display("ERROR %s: sat_out high without data_valid_out at cycle %0d", cur_test, cyc);
	end
endtask

`endif

// ==== test/osf_tb.sv ====
`default_nettype none

module osf_tb import osf_pkg::*; ();

	localparam int W_IN         = 18;
	localparam int W_OUT        = 16;
	localparam int MAX_OS       = 7;
	localparam int PHASES       = 6;
	localparam int PHASE_LEN    = 300;
	localparam int RESET_CYCLES = 10;
	localparam int CYCLE_LIMIT  = PHASES * PHASE_LEN + RESET_CYCLES + 200;

	localparam logic signed [W_IN-1:0] FULL_POS = (1 << (W_IN - 1)) - 1;
	localparam logic signed [W_IN-1:0] FULL_NEG = -(1 << (W_IN - 1));

	logic                    clk_in = 1'b0;
	logic                    reset_in;
	logic                    cmd_valid;
	osf_cmd_t                cmd;
	logic signed [W_IN-1:0]  data_in;
	logic                    data_valid_in;
	logic signed [W_OUT-1:0] data_out;
	logic                    data_valid_out;
	logic                    sat_out;

	int    cyc = 0;		// rising edges so far
	string cur_test = "reset";
	int    errors;

	osf_channel_top #(
		.W_IN   (W_IN),
		.W_OUT  (W_OUT),
		.MAX_OS (MAX_OS)
	) i_dut (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.cmd_valid      (cmd_valid),
		.cmd            (cmd),
		.data_in        (data_in),
		.data_valid_in  (data_valid_in),
		.data_out       (data_out),
		.data_valid_out (data_valid_out),
		.sat_out        (sat_out)
	);

	`include "osf_checks.svh"

	always #10 clk_in = ~clk_in;	// period 20

	always @(posedge clk_in) begin
		cyc = cyc + 1;
		model_step();
		if (cyc >= CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	always @(negedge clk_in) watch_outputs();

	//////////////////////////////
	// stimulus helpers
	//////////////////////////////

	function automatic osf_cmd_t make_cmd(osf_op_e op, logic [15:0] data);
		osf_cmd_t c;
		c.op   = op;
		c.data = data;
		return c;
	endfunction

	function automatic string test_name(int phase);
		case (phase)
			0:       return "reset_idle";
			1:       return "ratios";
			2:       return "armed_update";
			3:       return "activation";
			4:       return "saturation";
			default: return "os_clamp";
		endcase
	endfunction

	task automatic drive_sample(int phase);
		logic signed [W_IN-1:0] v;
		v = W_IN'($urandom);
		if (phase == 4)
			v = $urandom_range(0, 1) ? FULL_POS : FULL_NEG;	// rails only
		data_in       <= v;
		data_valid_in <= ($urandom_range(0, 1) == 1);
	endtask

	task automatic drive_command(int phase, int off);
		osf_cmd_t c;
		logic     hit;
		osf_op_e  op;
		hit = 1'b1;
		case (phase * 1000 + off)	// scripted setup at each phase start
			0:       c = make_cmd(OP_SET_OS, 16'd2);	// staged while idle
			1:       c = make_cmd(OP_SET_DELAY, 16'd3);
			2:       c = make_cmd(OP_ARM, 16'd0);
			3:       c = make_cmd(OP_UPDATE, 16'd0);
			60:      c = make_cmd(OP_ACTIVATE, 16'd0);	// first outputs after this
			1000:    c = make_cmd(OP_ACTIVATE, 16'd0);
			1001:    c = make_cmd(OP_ARM, 16'd0);
			2000:    c = make_cmd(OP_DISARM, 16'd0);
			2001:    c = make_cmd(OP_SET_OS, 16'd5);
			2002:    c = make_cmd(OP_SET_DELAY, 16'd1);
			2003:    c = make_cmd(OP_UPDATE, 16'd0);	// dropped, disarmed
			3000:    c = make_cmd(OP_ARM, 16'd0);
			3001:    c = make_cmd(OP_SET_OS, 16'd1);
			3002:    c = make_cmd(OP_UPDATE, 16'd0);
			4000:    c = make_cmd(OP_ACTIVATE, 16'd0);
			4001:    c = make_cmd(OP_SET_OS, 16'd0);
			4002:    c = make_cmd(OP_SET_DELAY, 16'd0);
			4003:    c = make_cmd(OP_ARM, 16'd0);
			4004:    c = make_cmd(OP_UPDATE, 16'd0);
			5000:    c = make_cmd(OP_SET_OS, 16'd12);	// above MAX_OS
			5001:    c = make_cmd(OP_SET_DELAY, 16'd2);
			5002:    c = make_cmd(OP_ARM, 16'd0);
			5003:    c = make_cmd(OP_UPDATE, 16'd0);
			default: hit = 1'b0;
		endcase
		// sparse random commands, full-scale phase stays at os 0
		if (!hit && phase != 4 && (phase != 0 || off > 60) && $urandom_range(0, 19) == 0) begin
			op = osf_op_e'($urandom_range(0, 7));
			if (op == OP_DEACTIVATE && phase != 3)
				op = OP_UPDATE;
			case (op)
				OP_SET_OS:    c = make_cmd(op, 16'($urandom_range(0, (phase == 5) ? 15 : 7)));
				OP_SET_DELAY: c = make_cmd(op, 16'($urandom_range(0, 5)));
				default:      c = make_cmd(op, 16'($urandom));	// data unused
			endcase
			hit = 1'b1;
		end
		cmd_valid <= hit;
		if (hit)
			cmd <= c;
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int n;
		void'($urandom(32'ha307));
		reset_in      = 1'b1;
		cmd_valid     = 1'b0;
		cmd           = '0;
		data_in       = '0;
		data_valid_in = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_in);
		reset_in <= 1'b0;
		for (n = 0; n < PHASES * PHASE_LEN; n++) begin
			cur_test = test_name(n / PHASE_LEN);
			drive_sample(n / PHASE_LEN);
			drive_command(n / PHASE_LEN, n % PHASE_LEN);
			@(posedge clk_in);
		end
		cmd_valid     <= 1'b0;
		data_valid_in <= 1'b0;
		repeat (3) @(posedge clk_in);	// last sample through send and result
		while (exp_q.size() != 0)
			@(posedge clk_in);
		@(negedge clk_in);
		errors = err_value + err_timing + err_other;
		$display("osf_tb: %0d blocks checked, %0d value errors, %0d timing errors, %0d other errors",
			blocks_seen, err_value, err_timing, err_other);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/osf_channel_top.sv ====
`default_nettype none

module osf_channel_top import osf_pkg::*; #(
	parameter int W_IN   = 18,	// adc sample width
	parameter int W_OUT  = 16,	// averaged output width
	parameter int MAX_OS = 7	// largest log2 ratio, 15 at most
)(
	input  logic                    clk_in,
	input  logic                    reset_in,
	input  logic                    cmd_valid,
	input  osf_cmd_t                cmd,
	input  logic signed [W_IN-1:0]  data_in,
	input  logic                    data_valid_in,
	output logic signed [W_OUT-1:0] data_out,
	output logic                    data_valid_out,
	output logic                    sat_out
);

	//////////////////////////////
	// interconnect
	//////////////////////////////

	osf_params_t                   params;		// staged settings
	logic                          update;		// armed commit pulse
	logic                          active;		// channel on level
	logic signed [W_IN+MAX_OS-1:0] sum;			// finished block sum
	logic [OS_FIELD_W-1:0]         os_cur;		// live log2 ratio
	logic                          block_done;	// filter in ST_SEND

	// decode
	fp_param_decoder #(
		.MAX_OS (MAX_OS)
	) i_decoder (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.params    (params),
		.update    (update),
		.active    (active)
	);

	// execute
	oversample_filter #(
		.W_IN   (W_IN),
		.MAX_OS (MAX_OS)
	) i_filter (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.data_in       (data_in),
		.data_valid_in (data_valid_in),
		.params        (params),
		.update        (update),
		.active        (active),
		.sum           (sum),
		.os_cur        (os_cur),
		.block_done    (block_done)
	);

	// result
	osf_result_stage #(
		.W_IN   (W_IN),
		.W_OUT  (W_OUT),
		.MAX_OS (MAX_OS)
	) i_result (
		.clk_in         (clk_in),
		.reset_in       (reset_in),
		.sum            (sum),
		.os_cur         (os_cur),
		.block_done     (block_done),
		.data_out       (data_out),
		.data_valid_out (data_valid_out),
		.sat_out        (sat_out)
	);

endmodule

`default_nettype wire

// ==== logic/osf_result_stage.sv ====
`default_nettype none

module osf_result_stage import osf_pkg::*; #(
	parameter int W_IN   = 18,	// input sample width
	parameter int W_OUT  = 16,	// output width
	parameter int MAX_OS = 7	// largest log2 ratio
)(
	input  logic                          clk_in,
	input  logic                          reset_in,

	// from the filter
	input  logic signed [W_IN+MAX_OS-1:0] sum,
	input  logic [OS_FIELD_W-1:0]         os_cur,
	input  logic                          block_done,

	// channel outputs
	output logic signed [W_OUT-1:0]       data_out,
	output logic                          data_valid_out,	// one-cycle pulse
	output logic                          sat_out			// qualified by valid
);

	//////////////////////////////
	// local signals
	//////////////////////////////

	localparam int W_SUM = W_IN + MAX_OS;
	localparam int W_EXT = (W_SUM > W_OUT) ? W_SUM : W_OUT;	// wide enough for both

	// signed output limits at the extended width
	localparam logic signed [W_EXT-1:0] OUT_MAX = (W_EXT'(1) << (W_OUT - 1)) - 1;
	localparam logic signed [W_EXT-1:0] OUT_MIN = -OUT_MAX - 1;

	logic signed [W_EXT-1:0] avg;		// sum / 2^os, floor
	logic signed [W_OUT-1:0] avg_clamped;
	logic                    sat;		// clamping happened

	assign avg = sum >>> os_cur;	// arithmetic, rounds toward -inf

	always_comb begin
		sat = 1'b1;
		if (avg > OUT_MAX)
			avg_clamped = OUT_MAX[W_OUT-1:0];	// positive rail
		else if (avg < OUT_MIN)
			avg_clamped = OUT_MIN[W_OUT-1:0];	// negative rail
		else begin
			avg_clamped = avg[W_OUT-1:0];
			sat         = 1'b0;
		end
	end

	//////////////////////////////
	// output registers
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (block_done)
			data_out <= avg_clamped;	// payload, holds between blocks
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_valid_out <= 1'b0;
			sat_out        <= 1'b0;
		end else begin
			data_valid_out <= block_done;
			sat_out        <= block_done && sat;
		end
	end

	// filter guarantees single-cycle send, so valid never repeats
	a_valid_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid_out |=> !data_valid_out);

endmodule

`default_nettype wire

// ==== logic/oversample_filter.sv ====
`default_nettype none

module oversample_filter import osf_pkg::*; #(
	parameter int W_IN   = 18,	// input sample width
	parameter int MAX_OS = 7	// largest log2 ratio
)(
	input  logic                          clk_in,
	input  logic                          reset_in,

	// adc samples
	input  logic signed [W_IN-1:0]        data_in,
	input  logic                          data_valid_in,	// may come on any cycle

	// from the decoder
	input  osf_params_t                   params,
	input  logic                          update,
	input  logic                          active,

	// to the result stage
	output logic signed [W_IN+MAX_OS-1:0] sum,
	output logic [OS_FIELD_W-1:0]         os_cur,
	output logic                          block_done	// high only in ST_SEND
);

	//////////////////////////////
	// local signals
	//////////////////////////////

	localparam int W_CNT = 16;				// covers 2^15 and the 16 bit delay

	osf_state_e       state;
	logic [15:0]      cycle_delay;	// live settling delay
	logic [W_CNT-1:0] cnt;			// samples seen in this state
	logic [W_CNT-1:0] cnt_inc;
	logic [W_CNT-1:0] ratio;		// 2^os_cur
	logic             delay_done;	// leave ST_DELAY on this edge
	logic             block_full;	// last sample of the block arriving

	assign ratio   = W_CNT'(1) << os_cur;
	assign cnt_inc = cnt + 1'b1;

	// zero delay leaves after one cycle, otherwise on the counted sample
	assign delay_done = (cnt >= cycle_delay) ||
		(data_valid_in && (cnt_inc >= cycle_delay));

	// count hits the ratio on the same edge that adds the last sample
	assign block_full = data_valid_in && (cnt_inc >= ratio);

	assign block_done = (state == ST_SEND);

	//////////////////////////////
	// live settings
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			os_cur      <= '0;
			cycle_delay <= '0;
		end else if (update) begin	// decoder already qualified with armed
			os_cur      <= params.os;
			cycle_delay <= params.cycle_delay;
		end
	end

	//////////////////////////////
	// fsm, counter, accumulator
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in || !active) begin	// inactive channel parks in idle, partial sum lost
			state <= ST_IDLE;
			cnt   <= '0;
			sum   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					state <= ST_SAMPLE;	// fresh block, no delay
					cnt   <= '0;
					sum   <= '0;
				end
				ST_SAMPLE: begin
					if (data_valid_in) begin
						sum <= sum + data_in;	// sign extends to the sum width
						cnt <= cnt_inc;
						if (block_full)
							state <= ST_SEND;
					end
				end
				ST_SEND: begin
					// result stage grabs sum on this edge
					state <= ST_DELAY;
					cnt   <= '0;
					sum   <= '0;	// sample in this cycle dropped
				end
				ST_DELAY: begin
					if (delay_done) begin
						state <= ST_SAMPLE;
						cnt   <= '0;
					end else if (data_valid_in) begin
						cnt <= cnt_inc;	// discarded, only counted
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// decoder clamp has to hold through the update path
	a_os_in_range: assert property (@(posedge clk_in) disable iff (reset_in)
		os_cur <= MAX_OS);

	// send is a single cycle, never back to back
	a_done_single: assert property (@(posedge clk_in) disable iff (reset_in)
		block_done |=> !block_done);

endmodule

`default_nettype wire

// ==== logic/fp_param_decoder.sv ====
`default_nettype none

module fp_param_decoder import osf_pkg::*; #(
	parameter int MAX_OS = 7	// largest log2 ratio allowed through
)(
	input  logic        clk_in,
	input  logic        reset_in,

	// front panel command stream
	input  logic        cmd_valid,	// one-cycle strobe
	input  osf_cmd_t    cmd,

	// to the filter
	output osf_params_t params,	// staged settings
	output logic        update,	// commit pulse, armed only
	output logic        active	// channel activation level
);

	//////////////////////////////
	// local signals
	//////////////////////////////

	localparam logic [OS_FIELD_W-1:0] OS_LIMIT = OS_FIELD_W'(MAX_OS);

	logic                  armed;		// update-enable flag
	logic [OS_FIELD_W-1:0] os_req;		// requested log2 ratio
	logic [OS_FIELD_W-1:0] os_clamped;	// limited to MAX_OS

	assign os_req     = cmd.data[OS_FIELD_W-1:0];	// upper data bits ignored
	assign os_clamped = (os_req > OS_LIMIT) ? OS_LIMIT : os_req;

	//////////////////////////////
	// command decode
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			params <= '0;	// ratio 1, no delay
			armed  <= 1'b0;
			active <= 1'b0;
			update <= 1'b0;
		end else begin
			update <= 1'b0;	// pulse by default
			if (cmd_valid) begin
				case (cmd.op)
					OP_SET_OS: begin
						params.os <= os_clamped;
					end
					OP_SET_DELAY: begin
						params.cycle_delay <= cmd.data;
					end
					OP_ACTIVATE: begin
						active <= 1'b1;
					end
					OP_DEACTIVATE: begin
						active <= 1'b0;
					end
					OP_ARM: begin
						armed <= 1'b1;
					end
					OP_DISARM: begin
						armed <= 1'b0;
					end
					OP_UPDATE: begin
						update <= armed;	// silently dropped when disarmed
					end
					default: begin
						// OP_NOP, nothing to do
					end
				endcase
			end
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// strobed opcode must be a known, defined value
	a_op_defined: assert property (@(posedge clk_in) disable iff (reset_in)
		cmd_valid |-> !$isunknown(cmd.op));

endmodule

`default_nettype wire

// ==== logic/osf_pkg.sv ====
`default_nettype none

package osf_pkg;

	//////////////////////////////
	// field widths
	//////////////////////////////

	localparam int OS_FIELD_W = 4;	// log2 ratio field, caps os at 15

	//////////////////////////////
	// front-panel opcodes
	//////////////////////////////

	typedef enum logic [2:0] {
		OP_NOP        = 3'd0,	// no effect
		OP_SET_OS     = 3'd1,	// stage log2 ratio from data[3:0]
		OP_SET_DELAY  = 3'd2,	// stage settling delay in samples
		OP_ACTIVATE   = 3'd3,	// channel on
		OP_DEACTIVATE = 3'd4,	// channel off, partial block dropped
		OP_ARM        = 3'd5,	// allow commits
		OP_DISARM     = 3'd6,	// block commits
		OP_UPDATE     = 3'd7	// commit staged settings if armed
	} osf_op_e;

	// command word as strobed in from the front panel
	typedef struct packed {
		osf_op_e     op;
		logic [15:0] data;
	} osf_cmd_t;

	// staged / live filter settings
	typedef struct packed {
		logic [OS_FIELD_W-1:0] os;			// log2 oversample ratio
		logic [15:0]           cycle_delay;	// samples dropped after each block
	} osf_params_t;

	//////////////////////////////
	// filter states
	//////////////////////////////

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,	// waiting for activation
		ST_DELAY  = 2'd1,	// settling, samples discarded
		ST_SAMPLE = 2'd2,	// accumulating the block
		ST_SEND   = 2'd3	// block finished, one cycle
	} osf_state_e;

endpackage

`default_nettype wire
